/* src/fir_params.svh */
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// datapath and bus widths
`define FIR_DATA_W        32
`define FIR_ADDR_W        12

// tap storage and sample history depth
`define FIR_MAX_TAPS      32
`define FIR_TAP_IDX_W     5

// register map
`define FIR_ADDR_CTRL     12'h00
`define FIR_ADDR_LEN      12'h10
`define FIR_ADDR_TAPNUM   12'h14
`define FIR_ADDR_TAP_BASE 12'h80

`endif

/* src/fir_pkg.sv */
`include "fir_params.svh"

package fir_pkg;

    // sample, coefficient and accumulator share one width
    typedef logic [`FIR_DATA_W-1:0]    data_t;
    typedef logic [`FIR_ADDR_W-1:0]    addr_t;
    typedef logic [`FIR_TAP_IDX_W-1:0] tap_idx_t;

    // one bit wider than an index so that 32 fits
    typedef logic [`FIR_TAP_IDX_W:0]   tap_cnt_t;
    typedef logic [`FIR_DATA_W-1:0]    len_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_WAIT_SAMPLE,
        ENG_MAC,
        ENG_OUTPUT
    } eng_state_t;

endpackage

/* src/fir_ctrl_if.sv */
`timescale 1ns/1ps

// register block <-> engine
interface fir_ctrl_if;

    logic               start;
    fir_pkg::tap_cnt_t  tap_num;
    fir_pkg::len_t      data_length;
    fir_pkg::tap_idx_t  coef_idx;
    fir_pkg::data_t     coef;
    logic               busy;
    logic               done;

    modport cfg (
        output start, tap_num, data_length, coef,
        input  coef_idx, busy, done
    );

    modport engine (
        input  start, tap_num, data_length, coef,
        output coef_idx, busy, done
    );

endinterface

/* src/fir_win_if.sv */
`timescale 1ns/1ps

// sample window <-> engine
interface fir_win_if;

    logic               clear;
    logic               want;
    logic               pushed;
    fir_pkg::tap_idx_t  age;
    fir_pkg::data_t     x;

    modport window (
        input  clear, want, age,
        output pushed, x
    );

    modport engine (
        output clear, want, age,
        input  pushed, x
    );

endinterface

/* src/fir_cfg_regs.sv */
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_cfg_regs (
    input  logic            axis_clk,
    input  logic            axis_rst_n,

    input  logic            awvalid,
    input  fir_pkg::addr_t  awaddr,
    output logic            awready,
    input  logic            wvalid,
    input  fir_pkg::data_t  wdata,
    output logic            wready,

    input  logic            arvalid,
    input  fir_pkg::addr_t  araddr,
    output logic            arready,
    output logic            rvalid,
    input  logic            rready,
    output fir_pkg::data_t  rdata,

    fir_ctrl_if.cfg         ctrl
);

    fir_pkg::data_t taps [`FIR_MAX_TAPS];
    fir_pkg::data_t tap_num_q;
    fir_pkg::data_t data_length_q;
    fir_pkg::data_t rd_val;
    logic           ap_start_q;
    logic           ap_done_q;
    logic           ap_idle_q;
    logic           wr_en;
    logic           rd_en;
    logic           lock;

    // taps occupy consecutive words from the base address
    function automatic logic tap_hit(fir_pkg::addr_t a);
        return (a >= `FIR_ADDR_TAP_BASE) && (a < `FIR_ADDR_TAP_BASE + 4 * `FIR_MAX_TAPS);
    endfunction

    assign wr_en = awready && wready && awvalid && wvalid;
    assign rd_en = arready && arvalid;
    // config frozen from the start write until the run is done
    assign lock  = ctrl.busy || !ap_idle_q;

    ////////////////////
    // handshakes and control bits

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready       <= 1'b0;
            wready        <= 1'b0;
            arready       <= 1'b0;
            rvalid        <= 1'b0;
            ap_start_q    <= 1'b0;
            ap_done_q     <= 1'b0;
            ap_idle_q     <= 1'b1;
            tap_num_q     <= '0;
            data_length_q <= '0;
        end else begin
            awready    <= awvalid && wvalid && !awready;
            wready     <= awvalid && wvalid && !awready;
            arready    <= arvalid && !arready && !rvalid;
            ap_start_q <= wr_en && (awaddr == `FIR_ADDR_CTRL) && wdata[0] && ap_idle_q;

            if (rd_en) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            if (ctrl.done) begin
                ap_done_q <= 1'b1;
            end else if (rd_en && (araddr == `FIR_ADDR_CTRL)) begin
                ap_done_q <= 1'b0;
            end

            if (ap_start_q) begin
                ap_idle_q <= 1'b0;
            end else if (ctrl.done) begin
                ap_idle_q <= 1'b1;
            end

            if (wr_en && !lock) begin
                if (awaddr == `FIR_ADDR_LEN) begin
                    data_length_q <= wdata;
                end
                if (awaddr == `FIR_ADDR_TAPNUM) begin
                    tap_num_q <= wdata;
                end
            end
        end
    end

    ////////////////////
    // tap storage and read data

    always_ff @(posedge axis_clk) begin
        if (wr_en && !lock && tap_hit(awaddr)) begin
            taps[awaddr[`FIR_TAP_IDX_W+1:2]] <= wdata;
        end
        if (rd_en) begin
            rdata <= rd_val;
        end
    end

    always_comb begin
        rd_val = '0;
        case (araddr)
            `FIR_ADDR_CTRL:   rd_val[2:0] = {ap_idle_q, ap_done_q, ap_start_q};
            `FIR_ADDR_LEN:    rd_val = data_length_q;
            `FIR_ADDR_TAPNUM: rd_val = tap_num_q;
            default: begin
                if (tap_hit(araddr) && !lock) begin
                    rd_val = taps[araddr[`FIR_TAP_IDX_W+1:2]];
                end
            end
        endcase
    end

    // engine side, counts above the storage depth are clamped
    assign ctrl.start       = ap_start_q;
    assign ctrl.data_length = data_length_q;
    assign ctrl.tap_num     = (tap_num_q > fir_pkg::data_t'(`FIR_MAX_TAPS)) ?
                              fir_pkg::tap_cnt_t'(`FIR_MAX_TAPS) :
                              tap_num_q[`FIR_TAP_IDX_W:0];
    assign ctrl.coef        = taps[ctrl.coef_idx];

    // a ready pulse always meets both valids, so it completes a write
    a_aw_w_ready: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (awready || wready) |-> wr_en)
        else $error("awready/wready raised without both valids");

endmodule

/* src/fir_sample_window.sv */
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_sample_window (
    input  logic            axis_clk,
    input  logic            axis_rst_n,

    input  logic            ss_tvalid,
    input  fir_pkg::data_t  ss_tdata,
    output logic            ss_tready,

    fir_win_if.window       win
);

    fir_pkg::data_t    hist [`FIR_MAX_TAPS];
    fir_pkg::tap_idx_t wptr;
    fir_pkg::tap_idx_t rd_ptr;
    logic              take;

    assign take = ss_tvalid && ss_tready;

    // one sample per request, ready drops right after the handshake
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ss_tready  <= 1'b0;
            win.pushed <= 1'b0;
            wptr       <= '0;
        end else begin
            ss_tready  <= win.want && !take;
            win.pushed <= take;
            if (win.clear) begin
                wptr <= '0;
            end else if (take) begin
                wptr <= wptr + 1'b1;
            end
        end
    end

    // history before the start reads as zero
    always_ff @(posedge axis_clk) begin
        if (win.clear) begin
            for (int i = 0; i < `FIR_MAX_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (take) begin
            hist[wptr] <= ss_tdata;
        end
    end

    // newest entry sits one behind the write pointer
    assign rd_ptr = wptr - win.age - fir_pkg::tap_idx_t'(1);
    assign win.x  = hist[rd_ptr];

    a_push_after_take: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        win.pushed |-> $past(ss_tvalid && ss_tready && win.want))
        else $error("pushed without an accepted sample");

endmodule

/* src/fir_mac_engine.sv */
`timescale 1ns/1ps

module fir_mac_engine (
    input  logic            axis_clk,
    input  logic            axis_rst_n,

    input  logic            sm_tready,
    output logic            sm_tvalid,
    output fir_pkg::data_t  sm_tdata,
    output logic            sm_tlast,

    fir_ctrl_if.engine      ctrl,
    fir_win_if.engine       win
);

    fir_pkg::eng_state_t state_q;
    fir_pkg::tap_idx_t   idx;
    fir_pkg::data_t      acc;
    fir_pkg::len_t       out_cnt;
    logic                mac_last;
    logic                out_take;

    assign mac_last = ({1'b0, idx} == ctrl.tap_num - 1'b1);
    assign out_take = sm_tvalid && sm_tready;

    ////////////////////
    // run sequencer

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state_q   <= fir_pkg::ENG_IDLE;
            idx       <= '0;
            out_cnt   <= '0;
            ctrl.done <= 1'b0;
        end else begin
            ctrl.done <= 1'b0;
            case (state_q)
                fir_pkg::ENG_IDLE: begin
                    if (ctrl.start) begin
                        out_cnt <= '0;
                        state_q <= fir_pkg::ENG_WAIT_SAMPLE;
                    end
                end
                fir_pkg::ENG_WAIT_SAMPLE: begin
                    if (win.pushed) begin
                        idx <= '0;
                        // no taps means a zero output straight away
                        state_q <= (ctrl.tap_num == '0) ? fir_pkg::ENG_OUTPUT
                                                        : fir_pkg::ENG_MAC;
                    end
                end
                fir_pkg::ENG_MAC: begin
                    idx <= idx + 1'b1;
                    if (mac_last) begin
                        state_q <= fir_pkg::ENG_OUTPUT;
                    end
                end
                fir_pkg::ENG_OUTPUT: begin
                    if (out_take) begin
                        out_cnt <= out_cnt + 1'b1;
                        if (sm_tlast) begin
                            ctrl.done <= 1'b1;
                            state_q   <= fir_pkg::ENG_IDLE;
                        end else begin
                            state_q <= fir_pkg::ENG_WAIT_SAMPLE;
                        end
                    end
                end
                default: state_q <= fir_pkg::ENG_IDLE;
            endcase
        end
    end

    ////////////////////
    // multiply-accumulate, wraps at 32 bits

    always_ff @(posedge axis_clk) begin
        if (state_q == fir_pkg::ENG_WAIT_SAMPLE && win.pushed) begin
            acc <= '0;
        end else if (state_q == fir_pkg::ENG_MAC) begin
            acc <= acc + win.x * ctrl.coef;
        end
    end

    // coefficient k pairs with the sample k places back
    assign ctrl.coef_idx = idx;
    assign win.age       = idx;
    assign ctrl.busy     = (state_q != fir_pkg::ENG_IDLE);

    // request a sample from the start pulse on, until one arrives
    assign win.clear = (state_q == fir_pkg::ENG_IDLE) && ctrl.start;
    assign win.want  = win.clear || (state_q == fir_pkg::ENG_WAIT_SAMPLE && !win.pushed);

    // output held in the accumulator until accepted
    assign sm_tvalid = (state_q == fir_pkg::ENG_OUTPUT);
    assign sm_tdata  = acc;
    assign sm_tlast  = sm_tvalid && (out_cnt + 1'b1 == ctrl.data_length);

    a_sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> (sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast)))
        else $error("sm_tdata changed under back-pressure");

endmodule

/* src/fir_top.sv */
`timescale 1ns/1ps

module fir_top (
    input  logic            axis_clk,
    input  logic            axis_rst_n,

    // AXI-lite write
    input  logic            awvalid,
    input  fir_pkg::addr_t  awaddr,
    output logic            awready,
    input  logic            wvalid,
    input  fir_pkg::data_t  wdata,
    output logic            wready,

    // AXI-lite read
    input  logic            arvalid,
    input  fir_pkg::addr_t  araddr,
    output logic            arready,
    output logic            rvalid,
    input  logic            rready,
    output fir_pkg::data_t  rdata,

    // AXI-stream in
    input  logic            ss_tvalid,
    input  fir_pkg::data_t  ss_tdata,
    output logic            ss_tready,

    // AXI-stream out
    input  logic            sm_tready,
    output logic            sm_tvalid,
    output fir_pkg::data_t  sm_tdata,
    output logic            sm_tlast
);

    fir_ctrl_if ctrl_if ();
    fir_win_if  win_if ();

    fir_cfg_regs cfg_regs_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ctrl       (ctrl_if)
    );

    fir_sample_window sample_window_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .win        (win_if)
    );

    fir_mac_engine mac_engine_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .ctrl       (ctrl_if),
        .win        (win_if)
    );

endmodule

/* sim/tb_fir_model.svh */
`ifndef TB_FIR_MODEL_SVH
`define TB_FIR_MODEL_SVH

// model state, taps and samples of the current run
fir_pkg::data_t rng_state = 32'h0f7383f4;
fir_pkg::data_t h_model [`FIR_MAX_TAPS];
fir_pkg::data_t x_model [N_SAMPLES];

// numerical recipes constants, full 32-bit period
function automatic fir_pkg::data_t lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

// y[n] = sum of h[k] * x[n-k], samples before the run are zero
function automatic fir_pkg::data_t expected_output(input int n, input int ntaps);
    fir_pkg::data_t sum;
    sum = '0;
    for (int k = 0; k < ntaps; k++) begin
        if (n - k >= 0) begin
            sum = sum + h_model[k] * x_model[n - k];
        end
    end
    return sum;
endfunction

function automatic fir_pkg::addr_t tap_addr(input int k);
    return fir_pkg::addr_t'(`FIR_ADDR_TAP_BASE + 4 * k);
endfunction

////////////////////
// AXI-lite master

task automatic axil_write(input fir_pkg::addr_t addr, input fir_pkg::data_t data);
    @(posedge axis_clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    wdata   <= data;
    @(posedge axis_clk);
    while (!(awready && wready)) begin
        @(posedge axis_clk);
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
endtask

// rready stays high, so rvalid lasts one cycle
task automatic axil_read(input fir_pkg::addr_t addr, output fir_pkg::data_t data);
    @(posedge axis_clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    @(posedge axis_clk);
    while (!arready) begin
        @(posedge axis_clk);
    end
    arvalid <= 1'b0;
    while (!rvalid) begin
        @(posedge axis_clk);
    end
    data = rdata;
endtask

`endif

/* sim/tb_fir_top.sv */
`timescale 1ns/1ps
`include "fir_params.svh"

module tb_fir_top;

    localparam int N_SAMPLES   = 40;
    // about 40 cycles a sample at 32 taps with stalls
    localparam int RUN_CYCLES  = 40 * N_SAMPLES;
    localparam int CYCLE_LIMIT = 2 * RUN_CYCLES + 800;

    logic           axis_clk = 1'b0;
    logic           axis_rst_n;
    logic           awvalid;
    fir_pkg::addr_t awaddr;
    logic           awready;
    logic           wvalid;
    fir_pkg::data_t wdata;
    logic           wready;
    logic           arvalid;
    fir_pkg::addr_t araddr;
    logic           arready;
    logic           rvalid;
    logic           rready;
    fir_pkg::data_t rdata;
    logic           ss_tvalid;
    fir_pkg::data_t ss_tdata;
    logic           ss_tready;
    logic           sm_tready;
    logic           sm_tvalid;
    fir_pkg::data_t sm_tdata;
    logic           sm_tlast;

    int             err_cnt = 0;
    int             check_cnt = 0;
    int             tests_run = 0;
    int             tests_failed = 0;
    int             cycle_cnt = 0;
    logic           held_q = 1'b0;
    fir_pkg::data_t held_data;

    `include "tb_fir_model.svh"

    fir_top fir_top_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    always #2 axis_clk = ~axis_clk;

    always @(posedge axis_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input fir_pkg::data_t expected,
                               input fir_pkg::data_t actual);
        check_cnt++;
        assert (actual == expected) else begin
            err_cnt++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    ////////////////////
    // register bus checks

    // address and data ready pulse together for one cycle, after both valids
    a_wr_ready: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (awready || wready) |->
            (awready && wready && $past(awvalid && wvalid) && !$past(awready)))
        else begin
            err_cnt++;
            $display("awready and wready did not pulse together after both valids at %0t",
                     $time);
        end

    // one arready pulse per read, read data the cycle after
    a_rd_ready: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        arready |=> (rvalid && !arready && $past(arvalid, 2)))
        else begin
            err_cnt++;
            $display("arready did not pulse once after arvalid, or rvalid did not follow, at %0t",
                     $time);
        end

    ////////////////////
    // stream checks

    // a held output keeps its value
    always @(posedge axis_clk) begin
        if (axis_rst_n && held_q) begin
            check_value("sm_tdata (held)", held_data, sm_tdata);
        end
        held_q    <= sm_tvalid && !sm_tready;
        held_data <= sm_tdata;
    end

    a_in_closed: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid |-> !ss_tready)
        else begin
            err_cnt++;
            $display("FAILED at %0t: ss_tready expected 0, got 1", $time);
        end

    a_valid_held: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> sm_tvalid)
        else begin
            err_cnt++;
            $display("FAILED at %0t: sm_tvalid expected 1, got 0", $time);
        end

    task automatic feed_samples();
        for (int i = 0; i < N_SAMPLES; i++) begin
            ss_tvalid <= 1'b1;
            ss_tdata  <= x_model[i];
            @(posedge axis_clk);
            while (!ss_tready) begin
                @(posedge axis_clk);
            end
        end
        ss_tvalid <= 1'b0;
    endtask

    // ready drops about one cycle in four when stalls are on
    task automatic drain_outputs(input int ntaps, input logic stalls);
        int             n;
        fir_pkg::data_t r;
        n = 0;
        while (n < N_SAMPLES) begin
            @(posedge axis_clk);
            if (sm_tvalid && sm_tready) begin
                check_value("sm_tdata", expected_output(n, ntaps), sm_tdata);
                check_value("sm_tlast", fir_pkg::data_t'(n == N_SAMPLES - 1),
                            fir_pkg::data_t'(sm_tlast));
                n++;
            end
            r = lcg_next();
            sm_tready <= stalls ? (r[31:30] != 2'b00) : 1'b1;
        end
    endtask

    // optional tap write in the middle of the run
    task automatic run_filter(input int ntaps, input logic stalls, input logic poke_tap);
        fork
            feed_samples();
            drain_outputs(ntaps, stalls);
            if (poke_tap) begin
                repeat (50) @(posedge axis_clk);
                axil_write(tap_addr(0), ~h_model[0]);
            end
        join
    endtask

    task automatic configure(input int ntaps);
        for (int k = 0; k < `FIR_MAX_TAPS; k++) begin
            h_model[k] = lcg_next();
        end
        for (int i = 0; i < N_SAMPLES; i++) begin
            x_model[i] = lcg_next();
        end
        axil_write(`FIR_ADDR_TAPNUM, ntaps);
        axil_write(`FIR_ADDR_LEN, N_SAMPLES);
        for (int k = 0; k < ntaps; k++) begin
            axil_write(tap_addr(k), h_model[k]);
        end
    endtask

    // polling read, the one that sees ap_done also clears it
    task automatic wait_done(output fir_pkg::data_t ctrl_val);
        ctrl_val = '0;
        while (!ctrl_val[1]) begin
            axil_read(`FIR_ADDR_CTRL, ctrl_val);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %-22s passed", name);
        end else begin
            tests_failed++;
            $display("test %-22s failed, %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        fir_pkg::data_t rd;
        int             errs_before;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b1;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        repeat (8) @(posedge axis_clk);
        axis_rst_n <= 1'b1;

        errs_before = err_cnt;
        configure(11);
        for (int k = 0; k < 11; k++) begin
            axil_read(tap_addr(k), rd);
            check_value($sformatf("rdata tap %0d", k), h_model[k], rd);
        end
        axil_read(12'h004, rd);
        check_value("rdata 0x004", '0, rd);
        axil_read(12'h020, rd);
        check_value("rdata 0x020", '0, rd);
        axil_read(12'h100, rd);
        check_value("rdata 0x100", '0, rd);
        report_test("tap_readback", errs_before);

        errs_before = err_cnt;
        axil_write(`FIR_ADDR_CTRL, 32'h1);
        run_filter(11, 1'b0, 1'b0);
        report_test("stream_11_taps", errs_before);

        errs_before = err_cnt;
        wait_done(rd);
        check_value("ap_idle", 32'h1, fir_pkg::data_t'(rd[2]));
        axil_read(`FIR_ADDR_CTRL, rd);
        check_value("ap_done", '0, fir_pkg::data_t'(rd[1]));
        check_value("ap_idle", 32'h1, fir_pkg::data_t'(rd[2]));
        report_test("completion", errs_before);

        errs_before = err_cnt;
        configure(32);
        axil_write(`FIR_ADDR_CTRL, 32'h1);
        run_filter(32, 1'b1, 1'b1);
        report_test("backpressure_32_taps", errs_before);

        errs_before = err_cnt;
        wait_done(rd);
        axil_read(tap_addr(0), rd);
        check_value("rdata tap 0", h_model[0], rd);
        report_test("busy_lockout", errs_before);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+src
+incdir+sim
src/fir_pkg.sv
src/fir_ctrl_if.sv
src/fir_win_if.sv
src/fir_cfg_regs.sv
src/fir_sample_window.sv
src/fir_mac_engine.sv
src/fir_top.sv
sim/tb_fir_top.sv

/* Makefile */
TOP := tb_fir_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall +incdir+src $$(grep '^src/' src.f) --top-module fir_top

clean:
	rm -rf obj_dir
